//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = audio_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Regression failed
PASS_MSG  = Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- files.f
source/audio_pkg.sv
source/audio_regs.sv
source/dac_boxcar.sv
source/iir_first_order.sv
source/iir_biquad.sv
source/speech_shaper.sv
source/audio_mixer.sv
source/audio_top.sv
testbench/audio_asserts.sv
testbench/audio_tb.sv

//--- source/audio_mixer.sv
// Mono mixer for the DAC and speech paths
// 17-bit sum scaled down to the output word, registered on dac_valid

`timescale 1ns/1ps

module audio_mixer (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   dac_valid,
	input  audio_pkg::pcm_t        dac_pcm,
	input  audio_pkg::pcm_t        speech_pcm,
	output audio_pkg::audio_out_t  audio_out,
	output logic                   audio_valid
);
	import audio_pkg::*;

	logic [PCM_W:0] mix_sum;

	// Carry kept so the sum never wraps
	assign mix_sum = {1'b0, dac_pcm} + {1'b0, speech_pcm};

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			audio_out   <= '0;
			audio_valid <= 1'b0;
		end else begin
			audio_valid <= dac_valid;
			if (dac_valid)
				audio_out <= audio_out_t'(mix_sum >> MIX_SHIFT);
		end
	end

endmodule

//--- source/audio_pkg.sv
// Shared definitions for the audio post-processing chain
// Sample widths and types, filter coefficient sets,
// AXI4-Lite request and response structs, control register layout
// and the 16-bit saturation helper used by the filters

package audio_pkg;

	//////////////////////////////
	// Widths
	localparam int DAC_W       = 8;
	localparam int PCM_W       = 16;
	localparam int COEF_W      = 22;
	localparam int COEF_SCALE  = 15;
	// Five 38-bit products summed, plus headroom
	localparam int ACC_W       = 42;
	localparam int SAT_IN_W    = ACC_W - COEF_SCALE;
	localparam int BOXCAR_LOG2 = 8;
	localparam int BOX_ACC_W   = DAC_W + BOXCAR_LOG2;
	localparam int AXIL_ADDR_W = 8;
	localparam int AXIL_DATA_W = 32;

	typedef logic        [DAC_W-1:0]  dac_sample_t;
	typedef logic        [PCM_W-1:0]  pcm_t;
	typedef logic signed [PCM_W-1:0]  spcm_t;
	typedef logic        [PCM_W-1:0]  audio_out_t;
	typedef logic signed [COEF_W-1:0] coef_t;

	localparam pcm_t PCM_MID = 16'h8000;
	// Half an LSB of the result, for round-to-nearest
	localparam logic signed [ACC_W-1:0] ACC_ROUND = ACC_W'(1) << (COEF_SCALE - 1);

	localparam int SPEECH_GAIN_SHIFT = 2;
	localparam int MIX_SHIFT         = 3;

	//////////////////////////////
	// Filter coefficients, scaled by 2^COEF_SCALE
	typedef struct packed {
		coef_t a2;
		coef_t a3;
		coef_t b1;
		coef_t b2;
		coef_t b3;
	} biquad_coef_t;

	// Low-pass near 3.5 kHz, Q about 0.69
	localparam biquad_coef_t SPEECH_STAGE1 = '{
		a2: -22'sd44251, a3: 22'sd16754, b1: 22'sd1318, b2: 22'sd2636, b3: 22'sd1318};
	// Low-pass near 3.3 kHz, Q about 0.70
	localparam biquad_coef_t SPEECH_STAGE2 = '{
		a2: -22'sd45163, a3: 22'sd17301, b1: 22'sd1226, b2: 22'sd2453, b3: 22'sd1226};

	// First-order smoothing, roughly 12 kHz corner
	localparam coef_t DAC_IIR_A2 = 22'sd613;
	localparam coef_t DAC_IIR_B1 = 22'sd16691;
	localparam coef_t DAC_IIR_B2 = 22'sd16690;

	//////////////////////////////
	// AXI4-Lite and control register
	typedef struct packed {
		logic                   awvalid;
		logic [AXIL_ADDR_W-1:0] awaddr;
		logic                   wvalid;
		logic [AXIL_DATA_W-1:0] wdata;
		logic [3:0]             wstrb;
		logic                   bready;
		logic                   arvalid;
		logic [AXIL_ADDR_W-1:0] araddr;
		logic                   rready;
	} axil_req_t;

	typedef struct packed {
		logic                   awready;
		logic                   wready;
		logic                   bvalid;
		logic [1:0]             bresp;
		logic                   arready;
		logic                   rvalid;
		logic [AXIL_DATA_W-1:0] rdata;
		logic [1:0]             rresp;
	} axil_rsp_t;

	localparam logic [AXIL_ADDR_W-1:0] REG_CTRL_ADDR = 8'h00;
	localparam logic [1:0]             AXI_RESP_OKAY = 2'b00;

	typedef struct packed {
		logic speech_filter_en;
	} ctrl_t;

	// Clamp a wide signed value into the 16-bit signed range
	function automatic spcm_t sat_spcm(input logic signed [SAT_IN_W-1:0] v);
		if (v > 32767)
			return 16'sh7FFF;
		else if (v < -32768)
			return 16'sh8000;
		else
			return v[PCM_W-1:0];
	endfunction

endpackage

//--- source/audio_regs.sv
// AXI4-Lite slave for the audio block
// Single-beat write and read channels, always OKAY
// Control register with the speech filter enable

`timescale 1ns/1ps

module audio_regs (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  audio_pkg::axil_req_t  axil_req,
	output audio_pkg::axil_rsp_t  axil_rsp,
	output audio_pkg::ctrl_t      ctrl
);
	import audio_pkg::*;

	logic                   aw_ready;
	logic                   b_valid;
	logic                   ar_ready;
	logic                   r_valid;
	logic [AXIL_DATA_W-1:0] r_data;
	logic                   wr_fire;
	logic                   rd_fire;

	assign wr_fire = aw_ready && axil_req.awvalid && axil_req.wvalid;
	assign rd_fire = ar_ready && axil_req.arvalid;

	//////////////////////////////
	// Write channel
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			aw_ready <= 1'b0;
			b_valid  <= 1'b0;
			ctrl     <= '0;
		end else begin
			// Address and data accepted together, one cycle per transfer
			aw_ready <= axil_req.awvalid && axil_req.wvalid && !b_valid && !aw_ready;
			if (wr_fire) begin
				b_valid <= 1'b1;
				if (axil_req.awaddr == REG_CTRL_ADDR && axil_req.wstrb[0])
					ctrl.speech_filter_en <= axil_req.wdata[0];
			end else if (b_valid && axil_req.bready) begin
				b_valid <= 1'b0;
			end
		end
	end

	//////////////////////////////
	// Read channel
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ar_ready <= 1'b0;
			r_valid  <= 1'b0;
		end else begin
			ar_ready <= axil_req.arvalid && !r_valid && !ar_ready;
			if (rd_fire)
				r_valid <= 1'b1;
			else if (r_valid && axil_req.rready)
				r_valid <= 1'b0;
		end
	end

	// Unmapped addresses read as zero
	always_ff @(posedge clk_sys) begin
		if (rd_fire)
			r_data <= (axil_req.araddr == REG_CTRL_ADDR) ? AXIL_DATA_W'(ctrl) : '0;
	end

	always_comb begin
		axil_rsp.awready = aw_ready;
		axil_rsp.wready  = aw_ready;
		axil_rsp.bvalid  = b_valid;
		axil_rsp.bresp   = AXI_RESP_OKAY;
		axil_rsp.arready = ar_ready;
		axil_rsp.rvalid  = r_valid;
		axil_rsp.rdata   = r_data;
		axil_rsp.rresp   = AXI_RESP_OKAY;
	end

endmodule

//--- source/audio_top.sv
// Top level of the audio post-processing block
// AXI4-Lite register block beside the DAC and speech datapath

`timescale 1ns/1ps

module audio_top (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  audio_pkg::dac_sample_t  dac_sample,
	input  audio_pkg::pcm_t         speech_sample,
	input  audio_pkg::axil_req_t    axil_req,
	output audio_pkg::axil_rsp_t    axil_rsp,
	output audio_pkg::audio_out_t   audio_out,
	output logic                    audio_valid
);
	import audio_pkg::*;

	ctrl_t ctrl;
	pcm_t  avg_sample;
	logic  sample_valid;
	pcm_t  dac_pcm;
	logic  dac_valid;
	pcm_t  speech_pcm;

	audio_regs regs0 (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.axil_req (axil_req),
		.axil_rsp (axil_rsp),
		.ctrl     (ctrl)
	);

	//////////////////////////////
	// DAC path
	dac_boxcar boxcar0 (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dac_sample   (dac_sample),
		.avg_sample   (avg_sample),
		.sample_valid (sample_valid)
	);

	iir_first_order dac_iir0 (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.in_valid  (sample_valid),
		.in_pcm    (avg_sample),
		.out_pcm   (dac_pcm),
		.out_valid (dac_valid)
	);

	//////////////////////////////
	// Speech path and mix
	speech_shaper speech0 (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.sample_valid  (sample_valid),
		.speech_sample (speech_sample),
		.ctrl          (ctrl),
		.speech_pcm    (speech_pcm)
	);

	audio_mixer mixer0 (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dac_valid   (dac_valid),
		.dac_pcm     (dac_pcm),
		.speech_pcm  (speech_pcm),
		.audio_out   (audio_out),
		.audio_valid (audio_valid)
	);

endmodule

//--- source/dac_boxcar.sv
// Boxcar averager for the sound-board DAC
// Free-running window counter, sets the chain's sample strobe

`timescale 1ns/1ps

module dac_boxcar (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  audio_pkg::dac_sample_t  dac_sample,
	output audio_pkg::pcm_t         avg_sample,
	output logic                    sample_valid
);
	import audio_pkg::*;

	logic [BOXCAR_LOG2-1:0] win_cnt;
	logic [BOX_ACC_W-1:0]   acc;
	logic [BOX_ACC_W-1:0]   sum_now;
	logic                   win_last;

	// Sum including the sample of the current cycle
	assign sum_now  = acc + BOX_ACC_W'(dac_sample);
	assign win_last = &win_cnt;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			win_cnt      <= '0;
			acc          <= '0;
			sample_valid <= 1'b0;
		end else begin
			win_cnt      <= win_cnt + 1'b1;
			sample_valid <= win_last;
			acc          <= win_last ? '0 : sum_now;
		end
	end

	// Average lands in the upper byte of the audio word
	always_ff @(posedge clk_sys) begin
		if (win_last)
			avg_sample <= pcm_t'(sum_now[BOX_ACC_W-1 -: DAC_W]) << (PCM_W - DAC_W);
	end

endmodule

//--- source/iir_biquad.sv
// Second-order IIR low-pass section, direct form I
// Coefficient set chosen by the COEF parameter
// Wide accumulator, saturated before the result is stored

`timescale 1ns/1ps

module iir_biquad #(
	parameter audio_pkg::biquad_coef_t COEF = audio_pkg::SPEECH_STAGE1
) (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              in_valid,
	input  audio_pkg::spcm_t  in_pcm,
	output audio_pkg::spcm_t  out_pcm,
	output logic              out_valid
);
	import audio_pkg::*;

	// Input and output history
	spcm_t                    x1;
	spcm_t                    x2;
	spcm_t                    y1;
	spcm_t                    y2;
	logic signed [ACC_W-1:0]  acc;
	spcm_t                    y_new;

	always_comb begin
		acc = $signed(COEF.b1) * in_pcm
			+ $signed(COEF.b2) * x1
			+ $signed(COEF.b3) * x2
			- $signed(COEF.a2) * y1
			- $signed(COEF.a3) * y2
			+ ACC_ROUND;
		y_new = sat_spcm(acc[ACC_W-1:COEF_SCALE]);
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			x1        <= '0;
			x2        <= '0;
			y1        <= '0;
			y2        <= '0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
			if (in_valid) begin
				x1 <= in_pcm;
				x2 <= x1;
				y1 <= y_new;
				y2 <= y1;
			end
		end
	end

	// Newest output is the registered result
	assign out_pcm = y1;

endmodule

//--- source/iir_first_order.sv
// First-order IIR smoothing filter for the DAC path
// y = (b1*x + b2*x[n-1] - a2*y[n-1]) / 2^COEF_SCALE, updated on each input strobe

`timescale 1ns/1ps

module iir_first_order (
	input  logic             clk_sys,
	input  logic             reset,
	input  logic             in_valid,
	input  audio_pkg::pcm_t  in_pcm,
	output audio_pkg::pcm_t  out_pcm,
	output logic             out_valid
);
	import audio_pkg::*;

	spcm_t                    x_in;
	spcm_t                    x1;
	spcm_t                    y1;
	logic signed [ACC_W-1:0]  acc;

	// Signed around midscale
	assign x_in = spcm_t'(in_pcm - PCM_MID);

	always_comb begin
		acc = $signed(DAC_IIR_B1) * x_in
			+ $signed(DAC_IIR_B2) * x1
			- $signed(DAC_IIR_A2) * y1
			+ ACC_ROUND;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			x1        <= '0;
			y1        <= '0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
			if (in_valid) begin
				x1 <= x_in;
				y1 <= sat_spcm(acc[ACC_W-1:COEF_SCALE]);
			end
		end
	end

	assign out_pcm = pcm_t'(y1) + PCM_MID;

endmodule

//--- source/speech_shaper.sv
// Speech path shaping
// Two cascaded low-pass biquads, gain of four with saturation,
// and a bypass that passes the raw captured sample

`timescale 1ns/1ps

module speech_shaper (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              sample_valid,
	input  audio_pkg::pcm_t   speech_sample,
	input  audio_pkg::ctrl_t  ctrl,
	output audio_pkg::pcm_t   speech_pcm
);
	import audio_pkg::*;

	spcm_t                      s_in;
	spcm_t                      s1;
	spcm_t                      s_out;
	logic                       s1_valid;
	logic signed [SAT_IN_W-1:0] s_boosted;
	pcm_t                       filtered_pcm;
	pcm_t                       raw_q;

	assign s_in = spcm_t'(speech_sample - PCM_MID);

	iir_biquad #(.COEF(SPEECH_STAGE1)) stage1 (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.in_valid  (sample_valid),
		.in_pcm    (s_in),
		.out_pcm   (s1),
		.out_valid (s1_valid)
	);

	iir_biquad #(.COEF(SPEECH_STAGE2)) stage2 (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.in_valid  (s1_valid),
		.in_pcm    (s1),
		.out_pcm   (s_out),
		.out_valid ()
	);

	// Gain of four, clamped to 16 bits, then back to unsigned
	assign s_boosted    = SAT_IN_W'(s_out) <<< SPEECH_GAIN_SHIFT;
	assign filtered_pcm = pcm_t'(sat_spcm(s_boosted)) + PCM_MID;

	// Raw sample held for the whole period
	always_ff @(posedge clk_sys) begin
		if (reset)
			raw_q <= PCM_MID;
		else if (sample_valid)
			raw_q <= speech_sample;
	end

	assign speech_pcm = ctrl.speech_filter_en ? filtered_pcm : raw_q;

endmodule

//--- testbench/audio_asserts.sv
// Concurrent checks on the audio block
// One-cycle output strobe, AXI response hold rules,
// no new write accepted while a write response is pending

`timescale 1ns/1ps

module audio_asserts (
	input logic                  clk_sys,
	input logic                  reset,
	input logic                  audio_valid,
	input audio_pkg::axil_req_t  axil_req,
	input audio_pkg::axil_rsp_t  axil_rsp
);

	valid_is_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		audio_valid |=> !audio_valid)
		else $error("audio_valid high on two consecutive cycles");

	// Responses wait for their ready
	bvalid_held: assert property (@(posedge clk_sys) disable iff (reset)
		axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
		else $error("bvalid dropped before bready");

	rvalid_held: assert property (@(posedge clk_sys) disable iff (reset)
		axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid)
		else $error("rvalid dropped before rready");

	no_write_while_resp: assert property (@(posedge clk_sys) disable iff (reset)
		axil_rsp.bvalid |-> !axil_rsp.awready && !axil_rsp.wready)
		else $error("write accepted while bvalid is pending");

endmodule

bind audio_top audio_asserts asserts0 (
	.clk_sys     (clk_sys),
	.reset       (reset),
	.audio_valid (audio_valid),
	.axil_req    (axil_req),
	.axil_rsp    (axil_rsp)
);

//--- testbench/audio_tb.sv
// Testbench for the audio post-processing block
// Clock and reset, AXI4-Lite master tasks, register tests,
// stimulus table applied in a loop, sample cadence monitor and watchdog

`timescale 1ns/1ps

module audio_tb;
	import audio_pkg::*;

	localparam int  NUM_ROWS       = 9;
	localparam int  SETTLE_PERIODS = 64;
	localparam int  PERIOD_CYCLES  = 1 << BOXCAR_LOG2;
	localparam int  AXI_TIMEOUT    = 64;
	localparam real CLK_NS         = 4.0;
	localparam real REG_TEST_NS    = 20000.0;
	localparam real WATCHDOG_NS    =
		2.0 * NUM_ROWS * SETTLE_PERIODS * PERIOD_CYCLES * CLK_NS + REG_TEST_NS;

	typedef struct packed {
		logic        filter_en;
		dac_sample_t dac;
		pcm_t        speech;
		audio_out_t  expected;
		audio_out_t  tol;
	} stim_row_t;

	logic        clk_sys;
	logic        reset;
	dac_sample_t dac_sample;
	pcm_t        speech_sample;
	axil_req_t   axil_req;
	axil_rsp_t   axil_rsp;
	audio_out_t  audio_out;
	logic        audio_valid;

	stim_row_t   table_rows[NUM_ROWS];
	string       row_name[NUM_ROWS];
	int          row_cnt = 0;
	int          cycle_cnt = 0;
	int          rel_cycle = 0;
	int          last_pulse = 0;
	logic        seen_pulse = 1'b0;
	logic        released = 1'b0;

	audio_top dut0 (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.dac_sample    (dac_sample),
		.speech_sample (speech_sample),
		.axil_req      (axil_req),
		.axil_rsp      (axil_rsp),
		.audio_out     (audio_out),
		.audio_valid   (audio_valid)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_NS / 2.0) clk_sys = ~clk_sys;
	end

	initial begin
		#(WATCHDOG_NS);
		abort_run("Watchdog expired before all tests finished");
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (expected !== actual) begin
			$display("ERR %s expected 0x%0h actual 0x%0h", name, expected, actual);
			abort_run("Stopping at the first mismatch");
		end
	endtask

	//////////////////////////////
	// Reference rules for the expected output
	function automatic pcm_t speech_term(input logic en, input pcm_t s);
		int boosted;
		if (!en)
			return s;
		boosted = (int'(s) - 32768) * 4;
		if (boosted > 32767)
			boosted = 32767;
		if (boosted < -32768)
			boosted = -32768;
		return pcm_t'(boosted + 32768);
	endfunction

	function automatic audio_out_t mix_rule(input dac_sample_t d, input pcm_t term);
		return audio_out_t'((int'(d) * 256 + int'(term)) / 8);
	endfunction

	// Approximate rows allow 1% of the expected output
	task automatic add_row(input string name, input logic en, input dac_sample_t d,
			input pcm_t s, input logic approx);
		audio_out_t e;
		audio_out_t t;
		e = mix_rule(d, speech_term(en, s));
		t = approx ? e / 100 : '0;
		row_name[row_cnt] = name;
		table_rows[row_cnt] = '{en, d, s, e, t};
		row_cnt++;
	endtask

	//////////////////////////////
	// AXI4-Lite master
	task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		int n;
		repeat ($urandom_range(3, 0)) @(negedge clk_sys);
		axil_req.awvalid = 1'b1;
		axil_req.awaddr  = addr;
		axil_req.wvalid  = 1'b1;
		axil_req.wdata   = data;
		axil_req.wstrb   = 4'hF;
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
			if (n > AXI_TIMEOUT)
				abort_run("Timeout waiting for awready and wready");
		end while (!(axil_rsp.awready && axil_rsp.wready));
		@(negedge clk_sys);
		axil_req.awvalid = 1'b0;
		axil_req.wvalid  = 1'b0;
		// Stall the response channel for a while
		repeat ($urandom_range(3, 0)) @(negedge clk_sys);
		axil_req.bready = 1'b1;
		n = 0;
		while (!axil_rsp.bvalid) begin
			@(negedge clk_sys);
			n++;
			if (n > AXI_TIMEOUT)
				abort_run("Timeout waiting for bvalid");
		end
		resp = axil_rsp.bresp;
		@(negedge clk_sys);
		axil_req.bready = 1'b0;
	endtask

	task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int n;
		repeat ($urandom_range(3, 0)) @(negedge clk_sys);
		axil_req.arvalid = 1'b1;
		axil_req.araddr  = addr;
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
			if (n > AXI_TIMEOUT)
				abort_run("Timeout waiting for arready");
		end while (!axil_rsp.arready);
		@(negedge clk_sys);
		axil_req.arvalid = 1'b0;
		repeat ($urandom_range(3, 0)) @(negedge clk_sys);
		axil_req.rready = 1'b1;
		n = 0;
		while (!axil_rsp.rvalid) begin
			@(negedge clk_sys);
			n++;
			if (n > AXI_TIMEOUT)
				abort_run("Timeout waiting for rvalid");
		end
		data = axil_rsp.rdata;
		resp = axil_rsp.rresp;
		@(negedge clk_sys);
		axil_req.rready = 1'b0;
	endtask

	task automatic wait_audio_valid();
		int n;
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
			if (n > 2 * PERIOD_CYCLES)
				abort_run("No audio_valid pulse within two sample periods");
		end while (!audio_valid);
	endtask

	task automatic check_idle(input string name);
		check({name, " audio_valid"}, 0, audio_valid);
		check({name, " bvalid"}, 0, axil_rsp.bvalid);
		check({name, " rvalid"}, 0, axil_rsp.rvalid);
		check({name, " awready"}, 0, axil_rsp.awready);
		check({name, " wready"}, 0, axil_rsp.wready);
		check({name, " arready"}, 0, axil_rsp.arready);
		check({name, " audio_out"}, 0, audio_out);
	endtask

	// Sample cadence monitor expects one pulse per window
	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (released && audio_valid) begin
			if (!seen_pulse)
				check("first_pulse_delay", 1, (cycle_cnt - rel_cycle) >= PERIOD_CYCLES);
			else
				check("pulse_interval", PERIOD_CYCLES, cycle_cnt - last_pulse);
			seen_pulse <= 1'b1;
			last_pulse <= cycle_cnt;
		end
	end

	//////////////////////////////
	// Main sequence
	initial begin
		logic [31:0] rdata;
		logic [1:0]  resp;
		stim_row_t   row;
		int          diff;
		void'($urandom(50));
		reset         = 1'b1;
		dac_sample    = '0;
		speech_sample = PCM_MID;
		axil_req      = '0;

		add_row("dac_mid_bypass", 1'b0, 8'h80, 16'h8000, 1'b1);
		add_row("dac_high_bypass", 1'b0, 8'hC0, 16'h8000, 1'b1);
		add_row("dac_low_bypass", 1'b0, 8'h20, 16'h8000, 1'b1);
		add_row("speech_bypass", 1'b0, 8'h80, 16'h9234, 1'b1);
		add_row("full_scale_bypass", 1'b0, 8'hFF, 16'hFFFF, 1'b1);
		add_row("speech_filter_pos", 1'b1, 8'h80, 16'h8400, 1'b1);
		add_row("speech_filter_neg", 1'b1, 8'h80, 16'h7C00, 1'b1);
		add_row("speech_sat_pos", 1'b1, 8'h80, 16'hA400, 1'b0);
		add_row("speech_sat_neg", 1'b1, 8'h80, 16'h5C00, 1'b0);

		repeat (4) begin
			@(negedge clk_sys);
			check_idle("during_reset");
		end
		reset     = 1'b0;
		rel_cycle = cycle_cnt;
		released  = 1'b1;
		@(negedge clk_sys);
		check_idle("after_reset");

		// Register access with random stalls
		axi_write(REG_CTRL_ADDR, 32'h1, resp);
		check("ctrl_write_bresp", AXI_RESP_OKAY, resp);
		axi_read(REG_CTRL_ADDR, rdata, resp);
		check("ctrl_read_data", 1, rdata);
		check("ctrl_read_rresp", AXI_RESP_OKAY, resp);
		axi_read(8'h10, rdata, resp);
		check("unmapped_read_data", 0, rdata);
		check("unmapped_read_rresp", AXI_RESP_OKAY, resp);
		axi_write(8'h24, 32'h0, resp);
		check("unmapped_write_bresp", AXI_RESP_OKAY, resp);
		axi_read(REG_CTRL_ADDR, rdata, resp);
		check("ctrl_after_unmapped_write", 1, rdata);
		axi_write(REG_CTRL_ADDR, 32'h0, resp);
		axi_read(REG_CTRL_ADDR, rdata, resp);
		check("ctrl_cleared", 0, rdata);

		for (int r = 0; r < row_cnt; r++) begin
			row = table_rows[r];
			axi_write(REG_CTRL_ADDR, 32'(row.filter_en), resp);
			check({row_name[r], " bresp"}, AXI_RESP_OKAY, resp);
			dac_sample    = row.dac;
			speech_sample = row.speech;
			repeat (SETTLE_PERIODS) wait_audio_valid();
			wait_audio_valid();
			if (row.tol != 0) begin
				diff = int'(audio_out) - int'(row.expected);
				if (diff < 0)
					diff = -diff;
				$display("%s expected 0x%0h +/- %0d actual 0x%0h",
					row_name[r], row.expected, row.tol, audio_out);
				check({row_name[r], " within_tolerance"}, 1, diff <= int'(row.tol));
			end else begin
				check(row_name[r], row.expected, audio_out);
			end
		end

		$display("Regression passed");
		$finish;
	end

endmodule
